// File: hw/switch_ctrl_pkg.sv
// switch controller shared definitions
`default_nettype none

package switch_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  // one spi transfer unit
  localparam int BYTE_W = 8;
  // free-running timestamp
  localparam int STAMP_W = 32;
  // enough to count the bits of one byte
  localparam int BIT_CNT_W = $clog2(BYTE_W);

  typedef logic [BYTE_W-1:0]  byte_t;
  typedef logic [STAMP_W-1:0] stamp_t;

  ////////////////////////////////////////////////////////////////////////////
  // command bytes, only the first byte of a frame is decoded

  localparam byte_t CMD_CLEAR_STAMP = 8'hCC;
  localparam byte_t CMD_SHORT_ON    = 8'hCD;
  localparam byte_t CMD_SHORT_OFF   = 8'hCE;

  ////////////////////////////////////////////////////////////////////////////
  // timing

  // flops per pin in the input synchronizer
  localparam int SYNC_DEPTH = 3;
  // about 2^22 cycles per half blink
  localparam int HEARTBEAT_BIT = 22;

  // command-frame tracking
  typedef enum logic [1:0] {
    FRAME_IDLE,
    FRAME_CMD,
    FRAME_DATA
  } frame_state_t;

endpackage

`default_nettype wire

// File: hw/spi_link_if.sv
// spi port to command fsm link
`timescale 1ns/10ps
`default_nettype none

interface spi_link_if (
  input logic clk,
  input logic rst
);
  import switch_ctrl_pkg::*;

  // frame events, one cycle each
  logic   frame_start;
  logic   frame_end;
  // received byte, rx_byte only meaningful while rx_valid is high
  logic   rx_valid;
  byte_t  rx_byte;
  // live timestamp, sampled by the port at frame start
  stamp_t tx_stamp;

  modport port (
    output frame_start,
    output frame_end,
    output rx_valid,
    output rx_byte,
    input  tx_stamp
  );

  modport ctrl (
    input  frame_start,
    input  frame_end,
    input  rx_valid,
    input  rx_byte,
    output tx_stamp
  );

  modport mon (
    input clk,
    input rst,
    input frame_start,
    input frame_end,
    input rx_valid,
    input rx_byte,
    input tx_stamp
  );

endinterface

`default_nettype wire

// File: hw/spi_target_port.sv
// spi mode 0 target port
`timescale 1ns/10ps
`default_nettype none

module spi_target_port (
  input  logic clk,
  input  logic rst,
  input  logic sck,
  input  logic ssel_n,
  input  logic mosi,
  output logic miso,
  spi_link_if.port link
);
  import switch_ctrl_pkg::*;

  // bit positions of the pins inside one synchronizer word
  localparam int PIN_SCK  = 2;
  localparam int PIN_SSEL = 1;
  localparam int PIN_MOSI = 0;
  // the last two stages are compared for edges
  localparam int STAGE_NEW = SYNC_DEPTH - 2;
  localparam int STAGE_OLD = SYNC_DEPTH - 1;
  // bus idle: sck low, target deselected
  localparam logic [2:0] PIN_IDLE = 3'b010;

  logic [2:0] pin_sync [SYNC_DEPTH];

  logic sck_new;
  logic sck_old;
  logic ssel_new;
  logic ssel_old;
  logic mosi_new;

  logic sck_rise;
  logic sck_fall;
  logic ssel_active;
  logic frame_start;
  logic frame_end;

  logic [BIT_CNT_W-1:0] bit_cnt;
  byte_t                rx_shift;
  logic                 rx_valid;
  stamp_t               tx_shift;

  ////////////////////////////////////////////////////////////////////////////
  // input synchronizer

  // all three pins move through the same chain of flops
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < SYNC_DEPTH; i++)
      begin
        pin_sync[i] <= PIN_IDLE;
      end
    end
    else
    begin
      pin_sync[0] <= {sck, ssel_n, mosi};
      for (int i = 1; i < SYNC_DEPTH; i++)
      begin
        pin_sync[i] <= pin_sync[i-1];
      end
    end
  end

  assign sck_new  = pin_sync[STAGE_NEW][PIN_SCK];
  assign sck_old  = pin_sync[STAGE_OLD][PIN_SCK];
  assign ssel_new = pin_sync[STAGE_NEW][PIN_SSEL];
  assign ssel_old = pin_sync[STAGE_OLD][PIN_SSEL];
  // mosi is stable for several cycles around the rising sck edge
  assign mosi_new = pin_sync[STAGE_NEW][PIN_MOSI];

  // edge events
  assign sck_rise    = sck_new & ~sck_old;
  assign sck_fall    = ~sck_new & sck_old;
  // ssel_n is active low
  assign ssel_active = ~ssel_new;
  assign frame_start = ~ssel_new & ssel_old;
  assign frame_end   = ssel_new & ~ssel_old;

  ////////////////////////////////////////////////////////////////////////////
  // receive path

  // counter held at zero between frames
  // so a cut-off byte cannot shift the next frame
  always_ff @(posedge clk)
  begin
    if (rst || !ssel_active)
    begin
      bit_cnt <= '0;
    end
    else if (sck_rise)
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // msb first, so shift left
  always_ff @(posedge clk)
  begin
    if (ssel_active && sck_rise)
    begin
      rx_shift <= {rx_shift[BYTE_W-2:0], mosi_new};
    end
  end

  // one pulse after the eighth rising edge, rx_shift then holds the full byte
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= ssel_active && sck_rise && (bit_cnt == BIT_CNT_W'(BYTE_W - 1));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // transmit path

  // snapshot at frame start, then one bit out per falling sck
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tx_shift <= '0;
    end
    else if (frame_start)
    begin
      tx_shift <= link.tx_stamp;
    end
    else if (ssel_active && sck_fall)
    begin
      tx_shift <= {tx_shift[STAMP_W-2:0], 1'b0};
    end
  end

  // single target on the bus, miso always driven
  assign miso = tx_shift[STAMP_W-1];

  // link outputs
  assign link.frame_start = frame_start;
  assign link.frame_end   = frame_end;
  assign link.rx_valid    = rx_valid;
  assign link.rx_byte     = rx_shift;

endmodule

`default_nettype wire

// File: hw/cmd_fsm.sv
// command frame state machine
`timescale 1ns/10ps
`default_nettype none

module cmd_fsm (
  input  logic                   clk,
  input  logic                   rst,
  spi_link_if.ctrl               link,
  input  switch_ctrl_pkg::stamp_t stamp,
  output logic                   clear_stamp,
  output logic                   short_en
);
  import switch_ctrl_pkg::*;

  frame_state_t state;
  frame_state_t state_nxt;
  logic         first_byte;

  ////////////////////////////////////////////////////////////////////////////
  // frame tracking

  // only the byte that arrives while waiting for a command counts
  assign first_byte = link.rx_valid && (state == FRAME_CMD);

  always_comb
  begin
    state_nxt = state;
    case (state)
      FRAME_IDLE:
      begin
        if (link.frame_start)
        begin
          state_nxt = FRAME_CMD;
        end
      end
      FRAME_CMD:
      begin
        // frame closed before a full byte
        if (link.frame_end)
        begin
          state_nxt = FRAME_IDLE;
        end
        else if (link.rx_valid)
        begin
          state_nxt = FRAME_DATA;
        end
      end
      FRAME_DATA:
      begin
        // remaining bytes are ignored until deselect
        if (link.frame_end)
        begin
          state_nxt = FRAME_IDLE;
        end
      end
      default:
      begin
        state_nxt = FRAME_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= FRAME_IDLE;
    end
    else
    begin
      state <= state_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // command decode

  // clear request goes straight to the counter
  // the counter register gives the one-cycle effect
  assign clear_stamp = first_byte && (link.rx_byte == CMD_CLEAR_STAMP);

  // switch state survives across frames, unknown bytes leave it alone
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      short_en <= 1'b0;
    end
    else if (first_byte)
    begin
      case (link.rx_byte)
        CMD_SHORT_ON:  short_en <= 1'b1;
        CMD_SHORT_OFF: short_en <= 1'b0;
        default:       short_en <= short_en;
      endcase
    end
  end

  // live count back to the port for the miso snapshot
  assign link.tx_stamp = stamp;

endmodule

`default_nettype wire

// File: hw/timebase.sv
// timestamp counter and heartbeat
`timescale 1ns/10ps
`default_nettype none

module timebase (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clear_stamp,
  output switch_ctrl_pkg::stamp_t stamp,
  output logic                    heartbeat
);
  import switch_ctrl_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // free-running counter

  // counts every cycle, wraps at 2^32
  // a clear request reads back as zero in the next cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      stamp <= '0;
    end
    else if (clear_stamp)
    begin
      stamp <= '0;
    end
    else
    begin
      stamp <= stamp + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // heartbeat led

  // a high counter bit gives a visible blink
  // restarts its phase after every clear
  assign heartbeat = stamp[HEARTBEAT_BIT];

endmodule

`default_nettype wire

// File: hw/switch_ctrl_top.sv
// spi switch controller top
`timescale 1ns/10ps
`default_nettype none

module switch_ctrl_top (
  input  logic clk,
  input  logic rst,
  // spi target pins, mode 0
  input  logic sck,
  input  logic ssel_n,
  input  logic mosi,
  output logic miso,
  // analog short switch and leds
  output logic short_en,
  output logic led_heartbeat,
  output logic led_status
);
  import switch_ctrl_pkg::*;

  stamp_t stamp;
  logic   clear_stamp;

  ////////////////////////////////////////////////////////////////////////////
  // link between port and fsm

  spi_link_if u_link (
    .clk (clk),
    .rst (rst)
  );

  ////////////////////////////////////////////////////////////////////////////
  // blocks

  // pin synchronizers, byte receive and miso shifter
  spi_target_port u_port (
    .clk    (clk),
    .rst    (rst),
    .sck    (sck),
    .ssel_n (ssel_n),
    .mosi   (mosi),
    .miso   (miso),
    .link   (u_link.port)
  );

  // first-byte decode, switch state
  cmd_fsm u_fsm (
    .clk         (clk),
    .rst         (rst),
    .link        (u_link.ctrl),
    .stamp       (stamp),
    .clear_stamp (clear_stamp),
    .short_en    (short_en)
  );

  timebase u_timebase (
    .clk         (clk),
    .rst         (rst),
    .clear_stamp (clear_stamp),
    .stamp       (stamp),
    .heartbeat   (led_heartbeat)
  );

  // status led shows the switch state
  assign led_status = short_en;

endmodule

`default_nettype wire

// File: tb/switch_ctrl_asserts.sv
// link and switch assertions
`timescale 1ns/10ps
`default_nettype none

module switch_ctrl_asserts (
  input logic clk,
  input logic rst,
  input logic frame_start,
  input logic frame_end,
  input logic rx_valid,
  input logic short_en
);

  // frame seen by the link, opened by frame_start and closed by frame_end
  logic in_frame;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      in_frame <= 1'b0;
    end
    else if (frame_start)
    begin
      in_frame <= 1'b1;
    end
    else if (frame_end)
    begin
      in_frame <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // link events

  // a byte only completes while the synchronized select is low
  a_rx_in_frame: assert property (
    @(posedge clk) disable iff (rst) rx_valid |-> in_frame)
    else $error("rx_valid high while the target is deselected");

  a_start_pulse: assert property (
    @(posedge clk) disable iff (rst) frame_start |=> !frame_start)
    else $error("frame_start held longer than one cycle");

  a_end_pulse: assert property (
    @(posedge clk) disable iff (rst) frame_end |=> !frame_end)
    else $error("frame_end held longer than one cycle");

  ////////////////////////////////////////////////////////////////////////////
  // switch output

  // the decode registers short_en one cycle after the byte arrives
  a_short_cause: assert property (
    @(posedge clk) disable iff (rst) (short_en != $past(short_en)) |-> $past(rx_valid))
    else $error("short_en changed without a received byte");

endmodule

// watch the link from inside the top level
bind switch_ctrl_top switch_ctrl_asserts u_asserts (
  .clk         (clk),
  .rst         (rst),
  .frame_start (u_link.frame_start),
  .frame_end   (u_link.frame_end),
  .rx_valid    (u_link.rx_valid),
  .short_en    (short_en)
);

`default_nettype wire

// File: tb/switch_ctrl_tb.sv
// switch controller testbench
`timescale 1ns/10ps
`default_nettype none

module switch_ctrl_tb;
  import switch_ctrl_pkg::*;

  localparam int CLK_HALF     = 50;
  localparam int DRIVE_DLY    = 5;
  localparam int RESET_CYCLES = 3;
  // spi timing in clk cycles
  localparam int SCK_HALF     = 4;
  localparam int GAP_CYCLES   = 4;
  localparam int FRAME_BYTES  = 4;
  localparam int FRAME_CYCLES = 3 * GAP_CYCLES + FRAME_BYTES * BYTE_W * 2 * SCK_HALF;
  // frames sent by all tests together
  localparam int NUM_FRAMES     = 13;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES * 2;

  logic clk;
  logic rst;
  logic sck;
  logic ssel_n;
  logic mosi;
  logic miso;
  logic short_en;
  logic led_heartbeat;
  logic led_status;

  int          cycle_cnt = 0;
  int          frame_start_cnt;
  int          frame_end_cnt;
  logic [31:0] rng_state = 32'd94;

  switch_ctrl_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .sck           (sck),
    .ssel_n        (ssel_n),
    .mosi          (mosi),
    .miso          (miso),
    .short_en      (short_en),
    .led_heartbeat (led_heartbeat),
    .led_status    (led_status)
  );

  always #(CLK_HALF) clk = ~clk;

  // run limit
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  // wait n rising edges, then step to the drive point
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #(DRIVE_DLY);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_filler(output byte_t b);
    rng_state = xorshift32(rng_state);
    b = rng_state[7:0];
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s (got %b, expected %b)", $time, msg, got, exp);
      $display(">>> FAIL");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // stamp must lie in lo..hi
  task automatic check_stamp(input stamp_t got, input stamp_t lo, input stamp_t hi,
                             input string msg);
    if ($isunknown(got) || got < lo || got > hi)
    begin
      $display("CHECK FAILED at %0t: %s (got %0d, expected %0d..%0d)",
               $time, msg, got, lo, hi);
      $display(">>> FAIL");
      $fatal(1, "stopping at the first error");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // spi host

  // mode 0, mosi set with sck low, miso read as sck rises
  task automatic send_byte(input byte_t tx_b, output byte_t rx_b);
    rx_b = '0;
    for (int i = BYTE_W - 1; i >= 0; i--)
    begin
      sck  = 1'b0;
      mosi = tx_b[i];
      step(SCK_HALF);
      sck     = 1'b1;
      rx_b[i] = miso;
      step(SCK_HALF);
    end
  endtask

  // four bytes per frame, enough to read the whole snapshot
  task automatic run_frame(input byte_t b0, input byte_t b1, input byte_t b2,
                           input byte_t b3, output stamp_t rd);
    byte_t tx [FRAME_BYTES];
    byte_t rx;
    tx[0] = b0;
    tx[1] = b1;
    tx[2] = b2;
    tx[3] = b3;
    rd = '0;
    frame_start_cnt = cycle_cnt;
    ssel_n = 1'b0;
    step(GAP_CYCLES);
    for (int n = 0; n < FRAME_BYTES; n++)
    begin
      send_byte(tx[n], rx);
      rd = {rd[STAMP_W-BYTE_W-1:0], rx};
    end
    sck = 1'b0;
    step(GAP_CYCLES);
    ssel_n = 1'b1;
    step(GAP_CYCLES);
    frame_end_cnt = cycle_cnt;
  endtask

  // first byte given, rest random
  task automatic cmd_frame(input byte_t cmd, output stamp_t rd);
    byte_t f1;
    byte_t f2;
    byte_t f3;
    next_filler(f1);
    next_filler(f2);
    next_filler(f3);
    run_frame(cmd, f1, f2, f3, rd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests

  task automatic test_reset_state();
    check_bit(short_en, 1'b0, "short_en after reset");
    check_bit(led_status, 1'b0, "led_status after reset");
    check_bit(miso, 1'b0, "miso after reset");
    check_bit(led_heartbeat, 1'b0, "led_heartbeat after reset");
  endtask

  task automatic test_switch_on_off();
    stamp_t rd;
    cmd_frame(CMD_SHORT_ON, rd);
    check_bit(short_en, 1'b1, "short_en after short on");
    check_bit(led_status, 1'b1, "led_status after short on");
    step(10);
    // unknown command, the switch keeps its state
    cmd_frame(8'h00, rd);
    check_bit(short_en, 1'b1, "short_en held across frames");
    cmd_frame(CMD_SHORT_OFF, rd);
    check_bit(short_en, 1'b0, "short_en after short off");
    check_bit(led_status, 1'b0, "led_status after short off");
  endtask

  task automatic test_first_byte_only();
    byte_t  unknown_cmds [4] = '{8'h00, 8'hCF, 8'hFF, 8'h33};
    byte_t  f2;
    byte_t  f3;
    stamp_t rd;
    next_filler(f2);
    next_filler(f3);
    run_frame(CMD_SHORT_ON, CMD_SHORT_OFF, f2, f3, rd);
    check_bit(short_en, 1'b1, "second byte of frame decoded");
    foreach (unknown_cmds[i])
    begin
      cmd_frame(unknown_cmds[i], rd);
      check_bit(short_en, 1'b1, "unknown first byte changed short_en");
    end
    next_filler(f2);
    next_filler(f3);
    run_frame(CMD_SHORT_OFF, CMD_SHORT_ON, f2, f3, rd);
    check_bit(short_en, 1'b0, "short off with trailing short on");
    check_bit(led_status, 1'b0, "led_status follows short_en");
  endtask

  task automatic test_clear_stamp();
    stamp_t rd;
    int     clear_end;
    int     bound;
    cmd_frame(CMD_CLEAR_STAMP, rd);
    clear_end = frame_end_cnt;
    cmd_frame(8'h00, rd);
    // clear lands inside the clear frame, at most one frame before its end
    bound = (frame_end_cnt - clear_end) + FRAME_CYCLES;
    check_stamp(rd, stamp_t'(1), stamp_t'(bound), "timestamp after clear");
  endtask

  task automatic test_stamp_order();
    stamp_t s1;
    stamp_t s2;
    int     start1;
    int     delta;
    cmd_frame(8'h00, s1);
    start1 = frame_start_cnt;
    step(20);
    cmd_frame(8'hFF, s2);
    delta = frame_start_cnt - start1;
    check_stamp(s2, s1 + stamp_t'(1), s1 + stamp_t'(delta + SYNC_DEPTH),
                "timestamp between two reads");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    clk    = 1'b0;
    rst    = 1'b1;
    sck    = 1'b0;
    ssel_n = 1'b1;
    mosi   = 1'b0;
    step(RESET_CYCLES);
    rst = 1'b0;
    step(1);
    test_reset_state();
    test_switch_on_off();
    test_first_byte_only();
    test_clear_stamp();
    test_stamp_order();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hw/switch_ctrl_pkg.sv
hw/spi_link_if.sv
hw/spi_target_port.sv
hw/cmd_fsm.sv
hw/timebase.sv
hw/switch_ctrl_top.sv
tb/switch_ctrl_asserts.sv
tb/switch_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the SPI switch controller

VERILATOR  ?= verilator
TOP        ?= switch_ctrl_tb
RTL_TOP    ?= switch_ctrl_top
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint lint-rtl clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: build
	./$(SIM)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

lint-rtl:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(filter hw/%,$(SOURCES))

clean:
	rm -rf $(BUILD_DIR)
